/* alu/rv_alu.sv */
`default_nettype none

`include "rv_consts.svh"

module rv_alu (
  input  wire rv_pkg::alu_op_e  op,
  input  wire [`RV_XLEN-1:0]    a,
  input  wire [`RV_XLEN-1:0]    b,
  output logic [`RV_XLEN-1:0]   result
);

  logic [4:0] shamt;

  // only the low five bits shift
  assign shamt = b[4:0];

  always_comb begin
    case (op)
      rv_pkg::ALU_ADD:    result = a + b;
      rv_pkg::ALU_SUB:    result = a - b;
      rv_pkg::ALU_SLL:    result = a << shamt;
      rv_pkg::ALU_SLT: begin
        result = {{(`RV_XLEN-1){1'b0}}, $signed(a) < $signed(b)};
      end
      rv_pkg::ALU_SLTU: begin
        result = {{(`RV_XLEN-1){1'b0}}, a < b};
      end
      rv_pkg::ALU_XOR:    result = a ^ b;
      rv_pkg::ALU_SRL:    result = a >> shamt;
      rv_pkg::ALU_SRA:    result = $unsigned($signed(a) >>> shamt);
      rv_pkg::ALU_OR:     result = a | b;
      rv_pkg::ALU_AND:    result = a & b;
      // lui, immediate is already shifted into place
      rv_pkg::ALU_PASS_B: result = b;
      default:            result = a + b;
    endcase
  end

endmodule

`default_nettype wire

/* common/rv_consts.svh */
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

// datapath and field widths
`define RV_XLEN       32
`define RV_REG_ADDR_W 5
`define RV_OPCODE_W   7

// accepted opcodes
`define RV_OP_LUI     7'b0110111
`define RV_OP_REG_IMM 7'b0010011
`define RV_OP_REG_REG 7'b0110011
`define RV_OP_BRANCH  7'b1100011
`define RV_OP_SYSTEM  7'b1110011

// funct3 for the alu groups
`define RV_F3_ADD  3'b000
`define RV_F3_SLL  3'b001
`define RV_F3_SLT  3'b010
`define RV_F3_SLTU 3'b011
`define RV_F3_XOR  3'b100
`define RV_F3_SR   3'b101
`define RV_F3_OR   3'b110
`define RV_F3_AND  3'b111

// funct3 for branches
`define RV_F3_BEQ  3'b000
`define RV_F3_BNE  3'b001
`define RV_F3_BLT  3'b100
`define RV_F3_BGE  3'b101
`define RV_F3_BLTU 3'b110
`define RV_F3_BGEU 3'b111

// funct7, alt selects sub and sra
`define RV_F7_BASE 7'b0000000
`define RV_F7_ALT  7'b0100000

`define RV_RESET_PC   32'h0000_0000
`define RV_INSN_BYTES 32'd4

`endif

/* common/rv_pkg.sv */
`default_nettype none

`include "rv_consts.svh"

package rv_pkg;

  // instruction formats, all views of the same 32-bit word
  typedef struct packed {
    logic [6:0]                  funct7;
    logic [`RV_REG_ADDR_W-1:0]   rs2;
    logic [`RV_REG_ADDR_W-1:0]   rs1;
    logic [2:0]                  funct3;
    logic [`RV_REG_ADDR_W-1:0]   rd;
    logic [`RV_OPCODE_W-1:0]     opcode;
  } r_fmt_s;

  typedef struct packed {
    logic [11:0]                 imm;
    logic [`RV_REG_ADDR_W-1:0]   rs1;
    logic [2:0]                  funct3;
    logic [`RV_REG_ADDR_W-1:0]   rd;
    logic [`RV_OPCODE_W-1:0]     opcode;
  } i_fmt_s;

  typedef struct packed {
    logic                        imm_12;
    logic [5:0]                  imm_10_5;
    logic [`RV_REG_ADDR_W-1:0]   rs2;
    logic [`RV_REG_ADDR_W-1:0]   rs1;
    logic [2:0]                  funct3;
    logic [3:0]                  imm_4_1;
    logic                        imm_11;
    logic [`RV_OPCODE_W-1:0]     opcode;
  } b_fmt_s;

  typedef struct packed {
    logic [19:0]                 imm20;
    logic [`RV_REG_ADDR_W-1:0]   rd;
    logic [`RV_OPCODE_W-1:0]     opcode;
  } u_fmt_s;

  typedef union packed {
    r_fmt_s r_fmt;
    i_fmt_s i_fmt;
    b_fmt_s b_fmt;
    u_fmt_s u_fmt;
  } insn_u;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
    ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS_B
  } alu_op_e;

  typedef enum logic [2:0] {
    BR_NONE, BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU
  } branch_e;

  typedef struct packed {
    alu_op_e                     alu_op;
    logic                        use_imm;
    logic [`RV_XLEN-1:0]         imm;
    branch_e                     branch;
    logic [`RV_XLEN-1:0]         branch_off;
    logic [`RV_REG_ADDR_W-1:0]   rd;
    logic [`RV_REG_ADDR_W-1:0]   rs1;
    logic [`RV_REG_ADDR_W-1:0]   rs2;
    logic                        rd_we;
    logic                        halt;
    logic                        illegal;
  } ctrl_s;

  // one retired instruction
  typedef struct packed {
    logic                        valid;
    logic                        illegal;
    logic                        rd_we;
    logic [`RV_REG_ADDR_W-1:0]   rd;
    logic [`RV_XLEN-1:0]         rd_data;
    logic [`RV_XLEN-1:0]         pc;
    logic [`RV_XLEN-1:0]         next_pc;
  } retire_s;

endpackage

`default_nettype wire

/* logic/rv_core.sv */
`default_nettype none

`include "rv_consts.svh"

module rv_core (
  input  wire                   clk,
  input  wire                   rst,
  input  wire rv_pkg::insn_u    insn,
  output logic [`RV_XLEN-1:0]   pc,
  output rv_pkg::retire_s       retire,
  output logic                  halt
);

  rv_pkg::ctrl_s       ctrl;
  logic [`RV_XLEN-1:0] rs1_data;
  logic [`RV_XLEN-1:0] rs2_data;
  logic [`RV_XLEN-1:0] alu_b;
  logic [`RV_XLEN-1:0] result;
  logic [`RV_XLEN-1:0] next_pc;

  rv_decoder u_decoder (
    .insn (insn),
    .ctrl (ctrl)
  );

  rv_regfile u_regfile (
    .clk      (clk),
    .rst      (rst),
    .rs1      (ctrl.rs1),
    .rs2      (ctrl.rs2),
    .rd       (ctrl.rd),
    .rd_we    (ctrl.rd_we),
    .rd_data  (result),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  // immediate or rs2 as second operand
  assign alu_b = ctrl.use_imm ? ctrl.imm : rs2_data;

  rv_alu u_alu (
    .op     (ctrl.alu_op),
    .a      (rs1_data),
    .b      (alu_b),
    .result (result)
  );

  rv_pc_unit u_pc_unit (
    .clk        (clk),
    .rst        (rst),
    .branch     (ctrl.branch),
    .branch_off (ctrl.branch_off),
    .halt       (ctrl.halt),
    .rs1_data   (rs1_data),
    .rs2_data   (rs2_data),
    .pc         (pc),
    .next_pc    (next_pc)
  );

  // nothing retires while in reset
  always_comb begin
    retire.valid   = !rst;
    retire.illegal = ctrl.illegal;
    retire.rd_we   = ctrl.rd_we && !rst;
    retire.rd      = ctrl.rd;
    retire.rd_data = result;
    retire.pc      = pc;
    retire.next_pc = next_pc;
  end

  assign halt = ctrl.halt && !rst;

endmodule

`default_nettype wire

/* logic/rv_decoder.sv */
`default_nettype none

`include "rv_consts.svh"

module rv_decoder (
  input  wire rv_pkg::insn_u insn,
  output rv_pkg::ctrl_s      ctrl
);

  logic [`RV_XLEN-1:0] imm_i;
  logic [`RV_XLEN-1:0] imm_b;
  logic [`RV_XLEN-1:0] imm_u;
  logic                f7_base;
  logic                f7_alt;
  logic                write;

  assign imm_i = {{(`RV_XLEN-12){insn.i_fmt.imm[11]}}, insn.i_fmt.imm};
  // b offset is scattered over the word, bit 0 always zero
  assign imm_b = {{(`RV_XLEN-13){insn.b_fmt.imm_12}}, insn.b_fmt.imm_12, insn.b_fmt.imm_11,
                  insn.b_fmt.imm_10_5, insn.b_fmt.imm_4_1, 1'b0};
  assign imm_u = {insn.u_fmt.imm20, 12'b0};

  assign f7_base = insn.r_fmt.funct7 == `RV_F7_BASE;
  assign f7_alt  = insn.r_fmt.funct7 == `RV_F7_ALT;

  always_comb begin
    ctrl            = '0;
    ctrl.alu_op     = rv_pkg::ALU_ADD;
    ctrl.branch     = rv_pkg::BR_NONE;
    ctrl.imm        = imm_i;
    ctrl.branch_off = imm_b;
    ctrl.rd         = insn.r_fmt.rd;
    ctrl.rs1        = insn.r_fmt.rs1;
    ctrl.rs2        = insn.r_fmt.rs2;
    write           = 1'b0;

    case (insn.r_fmt.opcode)
      `RV_OP_LUI: begin
        ctrl.alu_op  = rv_pkg::ALU_PASS_B;
        ctrl.use_imm = 1'b1;
        ctrl.imm     = imm_u;
        write        = 1'b1;
      end
      `RV_OP_REG_IMM: begin
        ctrl.use_imm = 1'b1;
        write        = 1'b1;
        case (insn.i_fmt.funct3)
          `RV_F3_ADD:  ctrl.alu_op = rv_pkg::ALU_ADD;
          `RV_F3_SLT:  ctrl.alu_op = rv_pkg::ALU_SLT;
          `RV_F3_SLTU: ctrl.alu_op = rv_pkg::ALU_SLTU;
          `RV_F3_XOR:  ctrl.alu_op = rv_pkg::ALU_XOR;
          `RV_F3_OR:   ctrl.alu_op = rv_pkg::ALU_OR;
          `RV_F3_AND:  ctrl.alu_op = rv_pkg::ALU_AND;
          // shift amount lives in imm[4:0], upper imm bits act as funct7
          `RV_F3_SLL: begin
            ctrl.alu_op  = rv_pkg::ALU_SLL;
            ctrl.illegal = !f7_base;
          end
          `RV_F3_SR: begin
            ctrl.alu_op  = f7_alt ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
            ctrl.illegal = !(f7_base || f7_alt);
          end
        endcase
      end
      `RV_OP_REG_REG: begin
        write = 1'b1;
        case (insn.r_fmt.funct3)
          `RV_F3_ADD:  ctrl.alu_op = f7_alt ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
          `RV_F3_SLL:  ctrl.alu_op = rv_pkg::ALU_SLL;
          `RV_F3_SLT:  ctrl.alu_op = rv_pkg::ALU_SLT;
          `RV_F3_SLTU: ctrl.alu_op = rv_pkg::ALU_SLTU;
          `RV_F3_XOR:  ctrl.alu_op = rv_pkg::ALU_XOR;
          `RV_F3_SR:   ctrl.alu_op = f7_alt ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
          `RV_F3_OR:   ctrl.alu_op = rv_pkg::ALU_OR;
          `RV_F3_AND:  ctrl.alu_op = rv_pkg::ALU_AND;
        endcase
        // only add and shift-right have an alt form
        ctrl.illegal = !(f7_base || (f7_alt && (insn.r_fmt.funct3 == `RV_F3_ADD ||
                                                insn.r_fmt.funct3 == `RV_F3_SR)));
      end
      `RV_OP_BRANCH: begin
        case (insn.b_fmt.funct3)
          `RV_F3_BEQ:  ctrl.branch = rv_pkg::BR_EQ;
          `RV_F3_BNE:  ctrl.branch = rv_pkg::BR_NE;
          `RV_F3_BLT:  ctrl.branch = rv_pkg::BR_LT;
          `RV_F3_BGE:  ctrl.branch = rv_pkg::BR_GE;
          `RV_F3_BLTU: ctrl.branch = rv_pkg::BR_LTU;
          `RV_F3_BGEU: ctrl.branch = rv_pkg::BR_GEU;
          default:     ctrl.illegal = 1'b1;
        endcase
      end
      `RV_OP_SYSTEM: begin
        // ecall only, every other bit must be clear
        if ({insn.i_fmt.imm, insn.i_fmt.rs1, insn.i_fmt.funct3, insn.u_fmt.rd} == '0) begin
          ctrl.halt = 1'b1;
        end else begin
          ctrl.illegal = 1'b1;
        end
      end
      default: ctrl.illegal = 1'b1;
    endcase

    // writes to x0 are reported as no write
    ctrl.rd_we = write && !ctrl.illegal && (ctrl.rd != '0);
  end

endmodule

`default_nettype wire

/* logic/rv_pc_unit.sv */
`default_nettype none

`include "rv_consts.svh"

module rv_pc_unit (
  input  wire                        clk,
  input  wire                        rst,
  input  wire rv_pkg::branch_e       branch,
  input  wire [`RV_XLEN-1:0]         branch_off,
  input  wire                        halt,
  input  wire [`RV_XLEN-1:0]         rs1_data,
  input  wire [`RV_XLEN-1:0]         rs2_data,
  output logic [`RV_XLEN-1:0]        pc,
  output logic [`RV_XLEN-1:0]        next_pc
);

  logic taken;

  always_comb begin
    case (branch)
      rv_pkg::BR_EQ:  taken = rs1_data == rs2_data;
      rv_pkg::BR_NE:  taken = rs1_data != rs2_data;
      rv_pkg::BR_LT:  taken = $signed(rs1_data) < $signed(rs2_data);
      rv_pkg::BR_GE:  taken = $signed(rs1_data) >= $signed(rs2_data);
      rv_pkg::BR_LTU: taken = rs1_data < rs2_data;
      rv_pkg::BR_GEU: taken = rs1_data >= rs2_data;
      default:        taken = 1'b0;
    endcase
  end

  // halt holds the pc on the ecall
  always_comb begin
    if (halt) begin
      next_pc = pc;
    end else if (taken) begin
      next_pc = pc + branch_off;
    end else begin
      next_pc = pc + `RV_INSN_BYTES;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= `RV_RESET_PC;
    end else begin
      pc <= next_pc;
    end
  end

endmodule

`default_nettype wire

/* project.f */
+incdir+common
common/rv_pkg.sv
logic/rv_decoder.sv
logic/rv_pc_unit.sv
alu/rv_alu.sv
regfile/rv_regfile.sv
logic/rv_core.sv
testbench/rv_core_props.sv
testbench/rv_core_tb.sv

/* regfile/rv_regfile.sv */
`default_nettype none

`include "rv_consts.svh"

module rv_regfile (
  input  wire                        clk,
  input  wire                        rst,
  input  wire [`RV_REG_ADDR_W-1:0]   rs1,
  input  wire [`RV_REG_ADDR_W-1:0]   rs2,
  input  wire [`RV_REG_ADDR_W-1:0]   rd,
  input  wire                        rd_we,
  input  wire [`RV_XLEN-1:0]         rd_data,
  output logic [`RV_XLEN-1:0]        rs1_data,
  output logic [`RV_XLEN-1:0]        rs2_data
);

  localparam int NUM_REGS = 1 << `RV_REG_ADDR_W;

  // x0 has no storage
  logic [`RV_XLEN-1:0] regs [1:NUM_REGS-1];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 1; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (rd_we && rd != '0) begin
      regs[rd] <= rd_data;
    end
  end

  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

/* testbench/rv_core_props.sv */
`default_nettype none

`include "rv_consts.svh"

module rv_core_props (
  input wire                  clk,
  input wire                  rst,
  input wire [`RV_XLEN-1:0]   pc,
  input wire rv_pkg::retire_s retire,
  input wire                  halt
);

  // quiet while in reset
  a_reset_quiet: assert property (@(posedge clk) rst |-> !retire.valid && !halt)
    else $error("retire.valid or halt high during reset");

  // halted core keeps its pc
  a_halt_hold: assert property (@(posedge clk) disable iff (rst) halt |=> pc == $past(pc))
    else $error("pc moved in the cycle after halt");

  a_illegal_no_write: assert property (@(posedge clk) disable iff (rst)
    retire.illegal |-> !retire.rd_we)
    else $error("illegal instruction reported a register write");

  a_no_x0_write: assert property (@(posedge clk) disable iff (rst)
    retire.rd_we |-> retire.rd != '0)
    else $error("register write reported for x0");

endmodule

bind rv_core rv_core_props u_props (
  .clk    (clk),
  .rst    (rst),
  .pc     (pc),
  .retire (retire),
  .halt   (halt)
);

`default_nettype wire

/* testbench/rv_core_tb.sv */
`default_nettype none

`include "rv_consts.svh"

module rv_core_tb;

  typedef struct packed {
    logic [31:0] word;
    logic [31:0] pc;
    logic        check_wb;
    logic        rd_we;
    logic [4:0]  rd;
    logic [31:0] rd_data;
    logic        illegal;
    logic [31:0] next_pc;
    logic        halt;
  } row_s;

  localparam logic [31:0] ECALL = {25'b0, `RV_OP_SYSTEM};

  logic            clk;
  logic            rst;
  rv_pkg::insn_u   insn;
  logic [31:0]     pc;
  rv_pkg::retire_s retire;
  logic            halt;

  row_s        rows[$];
  logic [31:0] xr [32];
  logic [31:0] cur_pc;

  rv_core uut (
    .clk    (clk),
    .rst    (rst),
    .insn   (insn),
    .pc     (pc),
    .retire (retire),
    .halt   (halt)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  function automatic logic [31:0] sext12(input logic [11:0] v);
    return {{20{v[11]}}, v};
  endfunction

  // differing sign bits decide the signed order, otherwise the unsigned order
  function automatic logic signed_less(input logic [31:0] a, input logic [31:0] b);
    return (a[31] != b[31]) ? a[31] : (a < b);
  endfunction

  // vacated upper bits take copies of the sign bit
  function automatic logic [31:0] shift_right_arith(input logic [31:0] v,
                                                    input logic [4:0] sh);
    logic [31:0] fill;
    fill = v[31] ? ~(32'hffff_ffff >> sh) : 32'h0;
    return (v >> sh) | fill;
  endfunction

  function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd);
    return {imm, rd, `RV_OP_LUI};
  endfunction

  function automatic logic [31:0] enc_i(input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [4:0] rs1, input logic [11:0] imm);
    return {imm, rs1, f3, rd, `RV_OP_REG_IMM};
  endfunction

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                        input logic [4:0] rd, input logic [4:0] rs1,
                                        input logic [4:0] rs2);
    return {f7, rs2, rs1, f3, rd, `RV_OP_REG_REG};
  endfunction

  // b offset bits are scattered over the word
  function automatic logic [31:0] enc_b(input logic [2:0] f3, input logic [4:0] rs1,
                                        input logic [4:0] rs2, input logic [12:0] off);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], `RV_OP_BRANCH};
  endfunction

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Some tests failed");
    $fatal(1, "stopping at first error");
  endtask

  task automatic mismatch(input string name, input logic [31:0] exp, input logic [31:0] act);
    fail_run($sformatf("Mismatch at time %0t: %s expected %h, got %h", $time, name, exp, act));
  endtask

  // row that writes back, rd of 0 means no write
  task automatic add_wb(input logic [31:0] word, input logic [4:0] rd, input logic [31:0] data);
    row_s r;
    r          = '0;
    r.word     = word;
    r.pc       = cur_pc;
    r.check_wb = 1'b1;
    r.rd_we    = rd != 5'd0;
    r.rd       = rd;
    r.rd_data  = data;
    r.next_pc  = cur_pc + 32'd4;
    rows.push_back(r);
    if (rd != 5'd0) begin
      xr[rd] = data;
    end
    cur_pc = r.next_pc;
  endtask

  // branch or illegal row, nothing written
  task automatic add_flow(input logic [31:0] word, input logic ill, input logic [31:0] nxt);
    row_s r;
    r         = '0;
    r.word    = word;
    r.pc      = cur_pc;
    r.illegal = ill;
    r.next_pc = nxt;
    rows.push_back(r);
    cur_pc = nxt;
  endtask

  task automatic build_table;
    logic [19:0] u_imm;
    logic [11:0] imm_neg;
    logic [11:0] imm_pos;
    logic [11:0] imm_c;
    logic [11:0] imm_d;
    logic [11:0] imm_e;
    logic [11:0] imm_f;
    logic [11:0] imm_g;
    logic [11:0] imm_h;
    logic [4:0]  sh_l;
    logic [4:0]  sh_r;
    logic [4:0]  sh_a;
    // x1 and x2 end up negative, x3 non-negative
    u_imm   = {2'b11, 18'($urandom)};
    imm_neg = {1'b1, 11'($urandom)};
    imm_pos = {1'b0, 11'($urandom)};
    imm_c   = 12'($urandom);
    imm_d   = 12'($urandom);
    imm_e   = 12'($urandom);
    imm_f   = 12'($urandom);
    imm_g   = 12'($urandom);
    imm_h   = 12'($urandom);
    sh_l    = 5'($urandom);
    sh_r    = 5'($urandom);
    sh_a    = {4'($urandom), 1'b1};
    for (int i = 0; i < 32; i++) begin
      xr[i] = '0;
    end
    cur_pc = `RV_RESET_PC;
    add_wb(enc_u(u_imm, 5'd1), 5'd1, {u_imm, 12'b0});
    add_wb(enc_i(`RV_F3_ADD, 5'd2, 5'd1, imm_neg), 5'd2, xr[1] + sext12(imm_neg));
    add_wb(enc_i(`RV_F3_ADD, 5'd3, 5'd0, imm_pos), 5'd3, sext12(imm_pos));
    add_wb(enc_i(`RV_F3_SLT, 5'd4, 5'd2, imm_c), 5'd4,
           {31'b0, signed_less(xr[2], sext12(imm_c))});
    add_wb(enc_i(`RV_F3_SLTU, 5'd5, 5'd3, imm_d), 5'd5, (xr[3] < sext12(imm_d)) ? 32'd1 : 32'd0);
    add_wb(enc_i(`RV_F3_XOR, 5'd6, 5'd2, imm_e), 5'd6, xr[2] ^ sext12(imm_e));
    add_wb(enc_i(`RV_F3_OR, 5'd7, 5'd3, imm_f), 5'd7, xr[3] | sext12(imm_f));
    add_wb(enc_i(`RV_F3_AND, 5'd8, 5'd2, imm_g), 5'd8, xr[2] & sext12(imm_g));
    add_wb(enc_i(`RV_F3_SLL, 5'd9, 5'd3, {7'b0, sh_l}), 5'd9, xr[3] << sh_l);
    add_wb(enc_i(`RV_F3_SR, 5'd10, 5'd2, {7'b0, sh_r}), 5'd10, xr[2] >> sh_r);
    add_wb(enc_i(`RV_F3_SR, 5'd11, 5'd2, {`RV_F7_ALT, sh_a}), 5'd11,
           shift_right_arith(xr[2], sh_a));
    add_wb(enc_r(`RV_F7_BASE, `RV_F3_ADD, 5'd12, 5'd2, 5'd3), 5'd12, xr[2] + xr[3]);
    // unsigned wrap, x2 is far above x3
    add_wb(enc_r(`RV_F7_ALT, `RV_F3_ADD, 5'd13, 5'd3, 5'd2), 5'd13, xr[3] - xr[2]);
    add_wb(enc_r(`RV_F7_BASE, `RV_F3_SLL, 5'd14, 5'd3, 5'd9), 5'd14, xr[3] << xr[9][4:0]);
    // signed and unsigned order of x2 and x3 differ
    add_wb(enc_r(`RV_F7_BASE, `RV_F3_SLT, 5'd15, 5'd2, 5'd3), 5'd15, 32'd1);
    add_wb(enc_r(`RV_F7_BASE, `RV_F3_SLTU, 5'd16, 5'd2, 5'd3), 5'd16, 32'd0);
    add_wb(enc_r(`RV_F7_BASE, `RV_F3_XOR, 5'd17, 5'd2, 5'd3), 5'd17, xr[2] ^ xr[3]);
    add_wb(enc_r(`RV_F7_BASE, `RV_F3_SR, 5'd18, 5'd2, 5'd9), 5'd18, xr[2] >> xr[9][4:0]);
    add_wb(enc_r(`RV_F7_ALT, `RV_F3_SR, 5'd19, 5'd2, 5'd9), 5'd19,
           shift_right_arith(xr[2], xr[9][4:0]));
    add_wb(enc_r(`RV_F7_BASE, `RV_F3_OR, 5'd20, 5'd6, 5'd7), 5'd20, xr[6] | xr[7]);
    add_wb(enc_r(`RV_F7_BASE, `RV_F3_AND, 5'd21, 5'd6, 5'd8), 5'd21, xr[6] & xr[8]);
    add_wb(enc_i(`RV_F3_ADD, 5'd0, 5'd3, imm_h), 5'd0, xr[3] + sext12(imm_h));
    add_wb(enc_r(`RV_F7_BASE, `RV_F3_ADD, 5'd22, 5'd0, 5'd3), 5'd22, xr[3]);
    // auipc, bad funct7, ebreak
    add_flow({20'h12345, 5'd23, 7'b0010111}, 1'b1, cur_pc + 32'd4);
    add_flow(enc_r(7'b0000001, `RV_F3_ADD, 5'd23, 5'd1, 5'd2), 1'b1, cur_pc + 32'd4);
    add_flow(32'h0010_0073, 1'b1, cur_pc + 32'd4);
    // x23 still zero proves the illegal rows wrote nothing
    add_flow(enc_b(`RV_F3_BEQ, 5'd23, 5'd0, 13'd8), 1'b0, cur_pc + 32'd8);
    add_flow(enc_b(`RV_F3_BEQ, 5'd2, 5'd3, 13'd8), 1'b0, cur_pc + 32'd4);
    add_flow(enc_b(`RV_F3_BNE, 5'd2, 5'd3, 13'd16), 1'b0, cur_pc + 32'd16);
    add_flow(enc_b(`RV_F3_BNE, 5'd22, 5'd3, 13'd8), 1'b0, cur_pc + 32'd4);
    // backward by 20
    add_flow(enc_b(`RV_F3_BLT, 5'd2, 5'd3, 13'h1fec), 1'b0, cur_pc - 32'd20);
    add_flow(enc_b(`RV_F3_BLT, 5'd3, 5'd2, 13'd8), 1'b0, cur_pc + 32'd4);
    add_flow(enc_b(`RV_F3_BGE, 5'd3, 5'd2, 13'd8), 1'b0, cur_pc + 32'd8);
    add_flow(enc_b(`RV_F3_BGE, 5'd2, 5'd3, 13'd8), 1'b0, cur_pc + 32'd4);
    add_flow(enc_b(`RV_F3_BLTU, 5'd3, 5'd2, 13'd12), 1'b0, cur_pc + 32'd12);
    add_flow(enc_b(`RV_F3_BLTU, 5'd2, 5'd3, 13'd8), 1'b0, cur_pc + 32'd4);
    add_flow(enc_b(`RV_F3_BGEU, 5'd2, 5'd3, 13'd8), 1'b0, cur_pc + 32'd8);
    add_flow(enc_b(`RV_F3_BGEU, 5'd3, 5'd2, 13'd8), 1'b0, cur_pc + 32'd4);
  endtask

  task automatic check_row(input row_s r);
    assert (retire.valid === 1'b1) else mismatch("retire.valid", 1'b1, retire.valid);
    assert (pc === r.pc) else mismatch("pc", r.pc, pc);
    assert (retire.pc === r.pc) else mismatch("retire.pc", r.pc, retire.pc);
    assert (retire.next_pc === r.next_pc) else mismatch("retire.next_pc", r.next_pc,
                                                         retire.next_pc);
    assert (retire.illegal === r.illegal) else mismatch("retire.illegal", r.illegal,
                                                         retire.illegal);
    assert (retire.rd_we === r.rd_we) else mismatch("retire.rd_we", r.rd_we, retire.rd_we);
    assert (halt === r.halt) else mismatch("halt", r.halt, halt);
    if (r.check_wb) begin
      assert (retire.rd === r.rd) else mismatch("retire.rd", r.rd, retire.rd);
      assert (retire.rd_data === r.rd_data) else mismatch("retire.rd_data", r.rd_data,
                                                           retire.rd_data);
    end
  endtask

  task automatic wait_valid;
    int cnt;
    cnt = 0;
    @(negedge clk);
    while (retire.valid !== 1'b1 && cnt < 20) begin
      cnt++;
      @(negedge clk);
    end
    if (retire.valid !== 1'b1) fail_run("Timeout: retire.valid never rose after reset release");
  endtask

  task automatic wait_halt;
    int cnt;
    cnt = 0;
    @(negedge clk);
    while (halt !== 1'b1 && cnt < 20) begin
      cnt++;
      @(negedge clk);
    end
    if (halt !== 1'b1) fail_run("Timeout: halt never rose while ecall was supplied");
  endtask

  initial begin
    void'($urandom(32'ha4d3));
    rst  = 1'b1;
    insn = '0;
    build_table();
    insn = rows[0].word;
    repeat (4) @(posedge clk);
    rst <= 1'b0;
    wait_valid();
    for (int i = 0; i < rows.size(); i++) begin
      if (i > 0) begin
        @(posedge clk);
        insn <= rows[i].word;
        @(negedge clk);
      end
      check_row(rows[i]);
    end
    // ecall at the pc after the last row
    @(posedge clk);
    insn <= ECALL;
    wait_halt();
    assert (pc === cur_pc) else mismatch("pc", cur_pc, pc);
    assert (retire.next_pc === cur_pc) else mismatch("retire.next_pc", cur_pc, retire.next_pc);
    assert (retire.rd_we === 1'b0) else mismatch("retire.rd_we", 1'b0, retire.rd_we);
    assert (retire.valid === 1'b1) else mismatch("retire.valid", 1'b1, retire.valid);
    repeat (3) begin
      @(posedge clk);
      insn <= ECALL;
      @(negedge clk);
      assert (pc === cur_pc) else mismatch("pc", cur_pc, pc);
      assert (halt === 1'b1) else mismatch("halt", 1'b1, halt);
    end
    $display("All tests passed");
    $finish;
  end

endmodule

`default_nettype wire
